// File: hw/ob_pkg.sv
/*
  Shared widths, encodings and record layouts of the order book.
  One instrument only. Prices are plain unsigned binary.
  A uid of all ones is reserved for trade responses.
  Unused response fields are always zero.
*/
package ob_pkg;

  // Order or command identifier
  typedef logic [7:0] uid_t;

  // Unsigned price
  typedef logic [15:0] price_t;

  // Share count
  typedef logic [11:0] quantity_t;

  // One bit wider than a quantity, holds a signed difference
  typedef logic signed [12:0] quantity_arith_t;

  typedef enum logic [1:0] {
    Op_Nop,
    Op_QryBidAsk,
    Op_Buy,
    Op_Sell
  } opcode_t;

  typedef enum logic [1:0] {
    S_Okay,
    S_Bad,
    S_Full
  } status_t;

  // Ingress command
  typedef struct packed {
    opcode_t   opcode;
    uid_t      uid;
    price_t    price;
    quantity_t quantity;
  } cmd_t;

  // One resting order
  typedef struct packed {
    uid_t      uid;
    price_t    price;
    quantity_t quantity;
  } entry_t;

  // Egress response
  typedef struct packed {
    uid_t      uid;
    status_t   status;
    // QryBidAsk result
    price_t    bid_price;
    price_t    ask_price;
    // Trade result
    uid_t      bid_uid;
    uid_t      ask_uid;
    quantity_t quantity;
  } rsp_t;

  // Originator id of every trade response
  localparam uid_t TRADE_UID = '1;

endpackage

// File: hw/ob_cmd_latch.sv
/*
  Single-entry command holding register.
  Refills in the cycle its command is consumed, so one command
  can wait here while another is being matched.
*/
`timescale 1ns/1ps

module ob_cmd_latch (
  input  logic         clk,
  input  logic         rst_n,
  // External command queue
  input  logic         cmd_in_vld,
  input  ob_pkg::cmd_t cmd_in,
  output logic         cmd_in_pop,
  // Controller side
  input  logic         cmd_consume,
  output logic         cmd_vld,
  output ob_pkg::cmd_t cmd
);

  // Fetch into an empty slot or one being freed this cycle
  assign cmd_in_pop = cmd_in_vld & (~cmd_vld | cmd_consume);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cmd_vld <= 1'b0;
    end else if (cmd_in_pop) begin
      cmd_vld <= 1'b1;
    end else if (cmd_consume) begin
      cmd_vld <= 1'b0;
    end
  end

  // Payload captured at the same edge as the pop
  always_ff @(posedge clk) begin
    if (cmd_in_pop) begin
      cmd <= cmd_in;
    end
  end

  // Controller only consumes a held command
  a_consume_held: assert property (
    @(posedge clk) disable iff (!rst_n) cmd_consume |-> cmd_vld
  );

endmodule

// File: hw/ob_table.sv
/*
  Sorted order table, best price at slot 0.
  IS_BID 1 sorts descending (bids), 0 ascending (asks).
  Equal prices keep arrival order, giving price-time priority.
  TABLE_DEPTH must be 2 or more. Inserting into a full table
  and popping an empty one are illegal; the controller checks full.
*/
`timescale 1ns/1ps

module ob_table #(
  parameter int TABLE_DEPTH = 4,
  parameter bit IS_BID      = 1'b1
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              insert,
  input  ob_pkg::entry_t    insert_entry,
  input  logic              pop,
  input  logic              update,
  input  ob_pkg::quantity_t update_quantity,
  output logic              head_vld,
  output ob_pkg::entry_t    head,
  output logic              full
);

  import ob_pkg::*;

  entry_t                 slot [TABLE_DEPTH];
  // Occupancy, always contiguous from slot 0
  logic [TABLE_DEPTH-1:0] vld;
  // New entry belongs at or ahead of this slot
  logic [TABLE_DEPTH-1:0] take;
  // Slot receives its lower neighbour
  logic [TABLE_DEPTH-1:0] shift;
  // Slot receives the new entry
  logic [TABLE_DEPTH-1:0] place;

  // Sorted contents make take monotonic
  always_comb begin
    for (int i = 0; i < TABLE_DEPTH; i++) begin
      if (IS_BID) begin
        take[i] = !vld[i] || (insert_entry.price > slot[i].price);
      end else begin
        take[i] = !vld[i] || (insert_entry.price < slot[i].price);
      end
    end
    shift = {take[TABLE_DEPTH-2:0], 1'b0};
    place = take & ~shift;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      vld <= '0;
    end else if (insert) begin
      vld <= {vld[TABLE_DEPTH-2:0], 1'b1};
    end else if (pop) begin
      vld <= {1'b0, vld[TABLE_DEPTH-1:1]};
    end
  end

  always_ff @(posedge clk) begin
    if (insert) begin
      if (place[0]) begin
        slot[0] <= insert_entry;
      end
      for (int i = 1; i < TABLE_DEPTH; i++) begin
        if (place[i]) begin
          slot[i] <= insert_entry;
        end else if (shift[i]) begin
          slot[i] <= slot[i-1];
        end
      end
    end else if (pop) begin
      // Move everything toward the head, last slot goes stale
      for (int i = 0; i < TABLE_DEPTH - 1; i++) begin
        slot[i] <= slot[i+1];
      end
    end else if (update) begin
      // Partial fill of the head order
      slot[0].quantity <= update_quantity;
    end
  end

  assign head     = slot[0];
  assign head_vld = vld[0];
  assign full     = vld[TABLE_DEPTH-1];

  a_no_insert_full: assert property (
    @(posedge clk) disable iff (!rst_n) insert |-> !full
  );

  a_no_pop_empty: assert property (
    @(posedge clk) disable iff (!rst_n) (pop || update) |-> head_vld
  );

  a_no_insert_pop: assert property (
    @(posedge clk) disable iff (!rst_n) !(insert && pop)
  );

endmodule

// File: hw/ob_match.sv
/*
  Compares the bid and ask heads and registers the trade decision.
  Results change only on cmp_en and hold until the next compare.
  Quantity and remainder are meaningful only with trade set.
*/
`timescale 1ns/1ps

module ob_match (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              cmp_en,
  input  logic              bid_vld,
  input  logic              ask_vld,
  input  ob_pkg::entry_t    bid_head,
  input  ob_pkg::entry_t    ask_head,
  output logic              trade,
  output logic              bid_consumed,
  output logic              ask_consumed,
  output ob_pkg::quantity_t quantity,
  output ob_pkg::quantity_t remainder
);

  import ob_pkg::*;

  logic            can_trade;
  // Bid quantity minus ask quantity
  quantity_arith_t diff;

  assign can_trade = bid_vld & ask_vld & (bid_head.price >= ask_head.price);
  assign diff      = quantity_arith_t'({1'b0, bid_head.quantity})
                   - quantity_arith_t'({1'b0, ask_head.quantity});

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      trade        <= 1'b0;
      bid_consumed <= 1'b0;
      ask_consumed <= 1'b0;
    end else if (cmp_en) begin
      trade        <= can_trade;
      // Smaller side fills completely, both on a tie
      bid_consumed <= can_trade && (diff <= 0);
      ask_consumed <= can_trade && (diff >= 0);
    end
  end

  always_ff @(posedge clk) begin
    if (cmp_en) begin
      if (diff < 0) begin
        // Ask is larger, remainder stays on the ask
        quantity  <= bid_head.quantity;
        remainder <= quantity_t'(-diff);
      end else begin
        // Zero remainder on equal quantities
        quantity  <= ask_head.quantity;
        remainder <= quantity_t'(diff);
      end
    end
  end

endmodule

// File: hw/ob_cntrl.sv
/*
  Order book controller FSM with states IDLE, QUERY and EXECUTE.
  A Buy or Sell is acknowledged on insert, then trades are matched
  one per QUERY/EXECUTE pass until the heads no longer cross.
  Every push waits for a non-full response queue.
  An order into a full table is answered with S_Full and dropped.
*/
`timescale 1ns/1ps

module ob_cntrl (
  input  logic              clk,
  input  logic              rst_n,
  // Command latch
  input  logic              cmd_vld,
  input  ob_pkg::cmd_t      cmd,
  output logic              cmd_consume,
  // Bid table
  output logic              bid_insert,
  output ob_pkg::entry_t    bid_insert_entry,
  output logic              bid_pop,
  output logic              bid_update,
  output ob_pkg::quantity_t bid_update_quantity,
  input  logic              bid_head_vld,
  input  ob_pkg::entry_t    bid_head,
  input  logic              bid_full,
  // Ask table
  output logic              ask_insert,
  output ob_pkg::entry_t    ask_insert_entry,
  output logic              ask_pop,
  output logic              ask_update,
  output ob_pkg::quantity_t ask_update_quantity,
  input  logic              ask_head_vld,
  input  ob_pkg::entry_t    ask_head,
  input  logic              ask_full,
  // Comparator
  output logic              cmp_en,
  input  logic              trade,
  input  logic              bid_consumed,
  input  logic              ask_consumed,
  input  ob_pkg::quantity_t quantity,
  input  ob_pkg::quantity_t remainder,
  // Response queue
  output logic              rsp_push,
  output ob_pkg::rsp_t      rsp,
  input  logic              rsp_full
);

  import ob_pkg::*;

  typedef enum logic [1:0] {
    IDLE,
    QUERY,
    EXECUTE
  } state_t;

  state_t state;
  state_t state_nxt;

  // New order built straight from the held command
  assign bid_insert_entry = '{uid: cmd.uid, price: cmd.price, quantity: cmd.quantity};
  assign ask_insert_entry = bid_insert_entry;

  // Survivor of a partial fill keeps the remainder
  assign bid_update_quantity = remainder;
  assign ask_update_quantity = remainder;

  always_comb begin
    state_nxt   = state;
    cmd_consume = 1'b0;
    bid_insert  = 1'b0;
    ask_insert  = 1'b0;
    bid_pop     = 1'b0;
    ask_pop     = 1'b0;
    bid_update  = 1'b0;
    ask_update  = 1'b0;
    cmp_en      = 1'b0;
    rsp_push    = 1'b0;
    rsp         = '0;

    case (state)
      IDLE: begin
        if (cmd_vld && !rsp_full) begin
          rsp_push   = 1'b1;
          rsp.uid    = cmd.uid;
          rsp.status = S_Okay;
          case (cmd.opcode)
            Op_QryBidAsk: begin
              cmd_consume = 1'b1;
              // Spread only valid with both sides present
              if (bid_head_vld && ask_head_vld) begin
                rsp.bid_price = bid_head.price;
                rsp.ask_price = ask_head.price;
              end else begin
                rsp.status = S_Bad;
              end
            end
            Op_Buy: begin
              if (bid_full) begin
                rsp.status  = S_Full;
                cmd_consume = 1'b1;
              end else begin
                bid_insert = 1'b1;
                state_nxt  = QUERY;
              end
            end
            Op_Sell: begin
              if (ask_full) begin
                rsp.status  = S_Full;
                cmd_consume = 1'b1;
              end else begin
                ask_insert = 1'b1;
                state_nxt  = QUERY;
              end
            end
            default: begin
              // Nop answers with its own uid
              cmd_consume = 1'b1;
            end
          endcase
        end
      end

      QUERY: begin
        // Heads have settled since the last table change
        cmp_en    = 1'b1;
        state_nxt = EXECUTE;
      end

      EXECUTE: begin
        if (!trade) begin
          // Book no longer crosses so the match loop ends
          cmd_consume = 1'b1;
          state_nxt   = IDLE;
        end else if (!rsp_full) begin
          bid_pop       = bid_consumed;
          ask_pop       = ask_consumed;
          bid_update    = !bid_consumed;
          ask_update    = !ask_consumed;
          rsp_push      = 1'b1;
          rsp.uid       = TRADE_UID;
          rsp.status    = S_Okay;
          rsp.bid_uid   = bid_head.uid;
          rsp.ask_uid   = ask_head.uid;
          rsp.quantity  = quantity;
          state_nxt     = QUERY;
        end
      end

      default: state_nxt = IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  // Held command stays put for the whole match loop
  a_cmd_held: assert property (
    @(posedge clk) disable iff (!rst_n) (state != IDLE) |-> cmd_vld
  );

  // A trade that fills neither head would never end the loop
  a_trade_fills: assert property (
    @(posedge clk) disable iff (!rst_n)
      (state == EXECUTE && trade) |-> (bid_consumed || ask_consumed)
  );

endmodule

// File: hw/ob_rsp_queue.sv
/*
  Egress response FIFO.
  Pop is ignored while empty. Pushing while full is illegal,
  the full flag is the controller's back-pressure.
  RSP_DEPTH must be 2 or more, any value.
*/
`timescale 1ns/1ps

module ob_rsp_queue #(
  parameter int RSP_DEPTH = 4
) (
  input  logic         clk,
  input  logic         rst_n,
  input  logic         push,
  input  ob_pkg::rsp_t push_rsp,
  output logic         full,
  input  logic         rsp_out_pop,
  output logic         rsp_out_vld,
  output ob_pkg::rsp_t rsp_out
);

  import ob_pkg::*;

  localparam int PTR_W = $clog2(RSP_DEPTH);
  localparam int CNT_W = $clog2(RSP_DEPTH + 1);

  rsp_t             mem [RSP_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             pop;

  assign pop         = rsp_out_pop & rsp_out_vld;
  assign full        = (count == CNT_W'(RSP_DEPTH));
  assign rsp_out_vld = (count != '0);
  assign rsp_out     = mem[rd_ptr];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      // Pointers wrap explicitly for non power of two depths
      if (push) begin
        wr_ptr <= (wr_ptr == PTR_W'(RSP_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(RSP_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= push_rsp;
    end
  end

  a_no_push_full: assert property (
    @(posedge clk) disable iff (!rst_n) push |-> !full
  );

endmodule

// File: hw/ob_top.sv
/*
  Order book top level for one instrument.
  Commands come from an external queue, responses leave through
  the internal response FIFO. Trade responses carry TRADE_UID.
*/
`timescale 1ns/1ps

module ob_top #(
  parameter int TABLE_DEPTH = 4,
  parameter int RSP_DEPTH   = 4
) (
  input  logic         clk,
  input  logic         rst_n,
  input  logic         cmd_in_vld,
  input  ob_pkg::cmd_t cmd_in,
  output logic         cmd_in_pop,
  output logic         rsp_out_vld,
  output ob_pkg::rsp_t rsp_out,
  input  logic         rsp_out_pop
);

  import ob_pkg::*;

  // Latch to controller
  logic      cmd_vld;
  cmd_t      cmd;
  logic      cmd_consume;

  // Table strobes and heads
  logic      bid_insert;
  logic      ask_insert;
  entry_t    bid_insert_entry;
  entry_t    ask_insert_entry;
  logic      bid_pop;
  logic      ask_pop;
  logic      bid_update;
  logic      ask_update;
  quantity_t bid_update_quantity;
  quantity_t ask_update_quantity;
  logic      bid_head_vld;
  logic      ask_head_vld;
  entry_t    bid_head;
  entry_t    ask_head;
  logic      bid_full;
  logic      ask_full;

  // Comparator result
  logic      cmp_en;
  logic      trade;
  logic      bid_consumed;
  logic      ask_consumed;
  quantity_t quantity;
  quantity_t remainder;

  // Controller to response queue
  logic      rsp_push;
  rsp_t      rsp;
  logic      rsp_full;

  ob_cmd_latch u_cmd_latch (
    .clk         (clk),
    .rst_n       (rst_n),
    .cmd_in_vld  (cmd_in_vld),
    .cmd_in      (cmd_in),
    .cmd_in_pop  (cmd_in_pop),
    .cmd_consume (cmd_consume),
    .cmd_vld     (cmd_vld),
    .cmd         (cmd)
  );

  // Bids sorted highest first
  ob_table #(
    .TABLE_DEPTH (TABLE_DEPTH),
    .IS_BID      (1'b1)
  ) u_bid_table (
    .clk             (clk),
    .rst_n           (rst_n),
    .insert          (bid_insert),
    .insert_entry    (bid_insert_entry),
    .pop             (bid_pop),
    .update          (bid_update),
    .update_quantity (bid_update_quantity),
    .head_vld        (bid_head_vld),
    .head            (bid_head),
    .full            (bid_full)
  );

  // Asks sorted lowest first
  ob_table #(
    .TABLE_DEPTH (TABLE_DEPTH),
    .IS_BID      (1'b0)
  ) u_ask_table (
    .clk             (clk),
    .rst_n           (rst_n),
    .insert          (ask_insert),
    .insert_entry    (ask_insert_entry),
    .pop             (ask_pop),
    .update          (ask_update),
    .update_quantity (ask_update_quantity),
    .head_vld        (ask_head_vld),
    .head            (ask_head),
    .full            (ask_full)
  );

  ob_match u_match (
    .clk          (clk),
    .rst_n        (rst_n),
    .cmp_en       (cmp_en),
    .bid_vld      (bid_head_vld),
    .ask_vld      (ask_head_vld),
    .bid_head     (bid_head),
    .ask_head     (ask_head),
    .trade        (trade),
    .bid_consumed (bid_consumed),
    .ask_consumed (ask_consumed),
    .quantity     (quantity),
    .remainder    (remainder)
  );

  ob_cntrl u_cntrl (
    .clk                 (clk),
    .rst_n               (rst_n),
    .cmd_vld             (cmd_vld),
    .cmd                 (cmd),
    .cmd_consume         (cmd_consume),
    .bid_insert          (bid_insert),
    .bid_insert_entry    (bid_insert_entry),
    .bid_pop             (bid_pop),
    .bid_update          (bid_update),
    .bid_update_quantity (bid_update_quantity),
    .bid_head_vld        (bid_head_vld),
    .bid_head            (bid_head),
    .bid_full            (bid_full),
    .ask_insert          (ask_insert),
    .ask_insert_entry    (ask_insert_entry),
    .ask_pop             (ask_pop),
    .ask_update          (ask_update),
    .ask_update_quantity (ask_update_quantity),
    .ask_head_vld        (ask_head_vld),
    .ask_head            (ask_head),
    .ask_full            (ask_full),
    .cmp_en              (cmp_en),
    .trade               (trade),
    .bid_consumed        (bid_consumed),
    .ask_consumed        (ask_consumed),
    .quantity            (quantity),
    .remainder           (remainder),
    .rsp_push            (rsp_push),
    .rsp                 (rsp),
    .rsp_full            (rsp_full)
  );

  ob_rsp_queue #(
    .RSP_DEPTH (RSP_DEPTH)
  ) u_rsp_queue (
    .clk         (clk),
    .rst_n       (rst_n),
    .push        (rsp_push),
    .push_rsp    (rsp),
    .full        (rsp_full),
    .rsp_out_pop (rsp_out_pop),
    .rsp_out_vld (rsp_out_vld),
    .rsp_out     (rsp_out)
  );

endmodule

// File: bench/ob_tb.sv
/*
  Self-checking testbench for the order book top level.
  Commands and expected responses come from bench/ob_stim.txt,
  expected responses listed in the order the book must emit them.
  Runs from the project root so the stim path resolves.
  Response pops are random, which lets the response FIFO fill up.
*/
`timescale 1ns/1ps

module ob_tb;

  import ob_pkg::*;

  logic clk;
  logic rst_n;
  logic cmd_in_vld;
  cmd_t cmd_in;
  logic cmd_in_pop;
  logic rsp_out_vld;
  rsp_t rsp_out;
  logic rsp_out_pop;

  // Stimulus and expected responses
  cmd_t   cmds [$];
  rsp_t   exps [$];
  int     n_cmd;
  int     n_exp;
  int     cmd_idx;
  int     exp_idx;
  bit     loaded;
  integer seed = 32'h1e0ba6c9;

  // Error counters
  int mismatches;
  int unexpected;
  int setup_errors;
  int timeouts;

  ob_top #(
    .TABLE_DEPTH (4)
  ) DUT (
    .clk         (clk),
    .rst_n       (rst_n),
    .cmd_in_vld  (cmd_in_vld),
    .cmd_in      (cmd_in),
    .cmd_in_pop  (cmd_in_pop),
    .rsp_out_vld (rsp_out_vld),
    .rsp_out     (rsp_out),
    .rsp_out_pop (rsp_out_pop)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Parses C and R lines and skips lines opening with #
  task automatic load_stim();
    integer          fd;
    integer          code;
    reg [8*8-1:0]    tag;
    reg [8*256-1:0]  rest;
    logic [3:0]      op;
    logic [7:0]      uid;
    logic [15:0]     price;
    logic [11:0]     qty;
    logic [3:0]      status;
    logic [15:0]     bid_price;
    logic [15:0]     ask_price;
    logic [7:0]      bid_uid;
    logic [7:0]      ask_uid;
    cmd_t            c;
    rsp_t            r;
    fd = $fopen("bench/ob_stim.txt", "r");
    if (fd == 0) begin
      $display("Cannot open the stimulus file bench/ob_stim.txt");
      setup_errors++;
      return;
    end
    while (!$feof(fd)) begin
      tag  = '0;
      code = $fscanf(fd, "%s", tag);
      if (code != 1) begin
        // End of file after the last line
      end else if (tag == "C") begin
        code = $fscanf(fd, "%h %h %h %h", op, uid, price, qty);
        c.opcode   = opcode_t'(op[1:0]);
        c.uid      = uid;
        c.price    = price;
        c.quantity = qty;
        cmds.push_back(c);
        if (code != 4) begin
          $display("Malformed command line in the stimulus file");
          setup_errors++;
        end
      end else if (tag == "R") begin
        code = $fscanf(fd, "%h %h %h %h %h %h %h", uid, status, bid_price,
                       ask_price, bid_uid, ask_uid, qty);
        r           = '0;
        r.uid       = uid;
        r.status    = status_t'(status[1:0]);
        r.bid_price = bid_price;
        r.ask_price = ask_price;
        r.bid_uid   = bid_uid;
        r.ask_uid   = ask_uid;
        r.quantity  = qty;
        exps.push_back(r);
        if (code != 7) begin
          $display("Malformed response line in the stimulus file");
          setup_errors++;
        end
      end else if (tag == "#") begin
        code = $fgets(rest, fd);
      end else begin
        $display("Unknown line type in the stimulus file");
        setup_errors++;
        code = $fgets(rest, fd);
      end
    end
    $fclose(fd);
    n_cmd = cmds.size();
    n_exp = exps.size();
  endtask

  task automatic check_field(input string name, input logic [15:0] got,
                             input logic [15:0] exp, input int idx);
    assert (got == exp) else begin
      mismatches++;
      $display("[ERROR] %0d ns: response %0d field %s is %h, expected %h",
               $time, idx, name, got, exp);
    end
  endtask

  // One popped response against the next expected one
  task automatic take_response(input rsp_t got);
    rsp_t exp;
    if (exp_idx >= n_exp) begin
      unexpected++;
      $display("Response with uid %h arrived after all expected responses", got.uid);
    end else begin
      exp = exps[exp_idx];
      check_field("uid", got.uid, exp.uid, exp_idx);
      check_field("status", got.status, exp.status, exp_idx);
      check_field("bid_price", got.bid_price, exp.bid_price, exp_idx);
      check_field("ask_price", got.ask_price, exp.ask_price, exp_idx);
      check_field("bid_uid", got.bid_uid, exp.bid_uid, exp_idx);
      check_field("ask_uid", got.ask_uid, exp.ask_uid, exp_idx);
      check_field("quantity", got.quantity, exp.quantity, exp_idx);
      exp_idx++;
    end
  endtask

  task automatic finish_run();
    int missing;
    missing = n_exp - exp_idx;
    if (missing > 0) begin
      $display("%0d expected responses never arrived", missing);
    end
    $display("Errors: %0d mismatched, %0d unexpected, %0d missing, %0d setup, %0d timeout",
             mismatches, unexpected, missing, setup_errors, timeouts);
    if (mismatches + unexpected + missing + setup_errors + timeouts == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  endtask

  // Head of the command queue moves on when the DUT pops it
  always @(posedge clk) begin
    if (rst_n) begin
      if (cmd_in_pop) begin
        cmd_idx++;
      end
      if (cmd_idx < n_cmd) begin
        cmd_in_vld <= 1'b1;
        cmd_in     <= cmds[cmd_idx];
      end else begin
        cmd_in_vld <= 1'b0;
      end
    end
  end

  // Response sink pops about one cycle in four
  always @(posedge clk) begin
    if (rst_n) begin
      if (rsp_out_pop && rsp_out_vld) begin
        take_response(rsp_out);
      end
      rsp_out_pop <= (($random(seed) & 3) == 0);
    end
  end

  initial begin
    rst_n       = 1'b0;
    cmd_in_vld  = 1'b0;
    cmd_in      = '0;
    rsp_out_pop = 1'b0;
    load_stim();
    if (setup_errors != 0) begin
      finish_run();
    end else begin
      loaded = 1'b1;
      repeat (10) @(posedge clk);
      rst_n <= 1'b1;
      while (exp_idx < n_exp) begin
        @(posedge clk);
      end
      // Short drain to catch extra or duplicate responses
      repeat (20) @(posedge clk);
      finish_run();
    end
  end

  // 200 cycles per command on top of reset
  initial begin
    wait (loaded);
    repeat (10 + 200 * n_cmd) @(posedge clk);
    $display("Timeout: the order book did not deliver all responses in %0d cycles",
             10 + 200 * n_cmd);
    timeouts++;
    finish_run();
  end

endmodule

// File: bench/ob_stim.txt
# C opcode uid price quantity   (hex; opcode 0 Nop, 1 QryBidAsk, 2 Buy, 3 Sell)
# R uid status bid_price ask_price bid_uid ask_uid quantity   (hex; status 0 Okay, 1 Bad, 2 Full)
C 0 01 1234 055
R 01 0 0000 0000 00 00 000
C 1 02 0000 000
R 02 1 0000 0000 00 00 000
C 2 03 0064 00a
R 03 0 0000 0000 00 00 000
C 1 04 0000 000
R 04 1 0000 0000 00 00 000
C 3 05 006e 00a
R 05 0 0000 0000 00 00 000
C 1 06 0000 000
R 06 0 0064 006e 00 00 000
C 3 07 0064 00a
R 07 0 0000 0000 00 00 000
R ff 0 0000 0000 03 07 00a
C 1 08 0000 000
R 08 1 0000 0000 00 00 000
C 3 09 0069 005
R 09 0 0000 0000 00 00 000
C 3 0a 0069 003
R 0a 0 0000 0000 00 00 000
C 2 0b 006e 014
R 0b 0 0000 0000 00 00 000
R ff 0 0000 0000 0b 09 005
R ff 0 0000 0000 0b 0a 003
R ff 0 0000 0000 0b 05 00a
C 3 0c 0078 004
R 0c 0 0000 0000 00 00 000
C 1 0d 0000 000
R 0d 0 006e 0078 00 00 000
C 2 0e 0064 001
R 0e 0 0000 0000 00 00 000
C 2 0f 005a 002
R 0f 0 0000 0000 00 00 000
C 2 10 0050 003
R 10 0 0000 0000 00 00 000
C 2 11 0046 004
R 11 2 0000 0000 00 00 000
C 1 12 0000 000
R 12 0 006e 0078 00 00 000
C 3 13 006e 002
R 13 0 0000 0000 00 00 000
R ff 0 0000 0000 0b 13 002
C 1 14 0000 000
R 14 0 0064 0078 00 00 000

// File: sources.f
hw/ob_pkg.sv
hw/ob_cmd_latch.sv
hw/ob_table.sv
hw/ob_match.sv
hw/ob_cntrl.sv
hw/ob_rsp_queue.sv
hw/ob_top.sv
bench/ob_tb.sv

// File: Bender.yml
package:
  name: order_book

sources:
  # Design, package first
  - files:
      - hw/ob_pkg.sv
      - hw/ob_cmd_latch.sv
      - hw/ob_table.sv
      - hw/ob_match.sv
      - hw/ob_cntrl.sv
      - hw/ob_rsp_queue.sv
      - hw/ob_top.sv

  # Testbench
  - target: test
    files:
      - bench/ob_tb.sv
